// ==== issue.f ====
verilog/issue_pkg.sv
verilog/ibuffer.sv
verilog/scoreboard.sv
verilog/operands.sv
verilog/dispatcher.sv
verilog/issue_slice.sv
test/tb_issue_slice.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the issue slice testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_issue_slice \
    -f issue.f --Mdir obj_dir -o Vtb_issue_slice
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_issue_slice > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== test/tb_issue_slice.sv ====
// 200 random instructions on registers 0 to 3 of 4 warps; the testbench plays both execution units
module tb_issue_slice import issue_pkg::*; ();

    localparam int          NUM_INSTR      = 200;
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] SEED           = 32'h4e6a;

    logic                clk             = 1'b0;
    logic                reset           = 1'b1;
    logic                decode_valid    = 1'b0;
    logic                decode_ready;
    logic [NW_BITS-1:0]  decode_wid      = '0;
    logic [PC_BITS-1:0]  decode_pc       = '0;
    ex_type_t            decode_ex_type  = EX_ALU;
    op_type_t            decode_op_type  = OP_ADD;
    logic                decode_wb       = 1'b0;
    logic [REG_BITS-1:0] decode_rd       = '0;
    logic [REG_BITS-1:0] decode_rs1      = '0;
    logic [REG_BITS-1:0] decode_rs2      = '0;
    logic                writeback_valid = 1'b0;
    logic [NW_BITS-1:0]  writeback_wid   = '0;
    logic [REG_BITS-1:0] writeback_rd    = '0;
    logic [XLEN-1:0]     writeback_data  = '0;
    logic                dispatch_valid    [NUM_EX_UNITS];
    logic                dispatch_ready    [NUM_EX_UNITS] = '{default: 1'b0};
    logic [NW_BITS-1:0]  dispatch_wid      [NUM_EX_UNITS];
    logic [PC_BITS-1:0]  dispatch_pc       [NUM_EX_UNITS];
    op_type_t            dispatch_op_type  [NUM_EX_UNITS];
    logic                dispatch_wb       [NUM_EX_UNITS];
    logic [REG_BITS-1:0] dispatch_rd       [NUM_EX_UNITS];
    logic [XLEN-1:0]     dispatch_rs1_data [NUM_EX_UNITS];
    logic [XLEN-1:0]     dispatch_rs2_data [NUM_EX_UNITS];
    logic                warp_issued;

    // generated program in decode order, with the source values the golden model expects
    logic [NW_BITS-1:0]  gen_wid [NUM_INSTR];
    logic [PC_BITS-1:0]  gen_pc  [NUM_INSTR];
    ex_type_t            gen_ex  [NUM_INSTR];
    op_type_t            gen_op  [NUM_INSTR];
    logic                gen_wb  [NUM_INSTR];
    logic [REG_BITS-1:0] gen_rd  [NUM_INSTR];
    logic [REG_BITS-1:0] gen_rs1 [NUM_INSTR];
    logic [REG_BITS-1:0] gen_rs2 [NUM_INSTR];
    logic [XLEN-1:0]     exp_rs1 [NUM_INSTR];
    logic [XLEN-1:0]     exp_rs2 [NUM_INSTR];

    // program order of each warp, consumed from warp_head as instructions leave
    int warp_list [NUM_WARPS][NUM_INSTR];
    int warp_cnt  [NUM_WARPS];
    int warp_head [NUM_WARPS];

    // results waiting for their execution delay to run out
    logic [NW_BITS-1:0]  wbq_wid  [$];
    logic [REG_BITS-1:0] wbq_rd   [$];
    logic [XLEN-1:0]     wbq_data [$];
    int                  wbq_due  [$];

    logic [31:0] stim_rng;
    int          stim_cycle;
    int          sent;
    int          dispatched   = 0;
    int          issued       = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic        reset_d      = 1'b0;

    issue_slice UUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // result of one instruction as the execution units compute it
    function automatic logic [XLEN-1:0] exec_ref(input op_type_t op, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b,
                                                 input logic [PC_BITS-1:0] pc);
        logic [XLEN-1:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            default: r = a ^ b;
        endcase
        return r + pc;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors = value_errors + 1;
        $display("Fail %s expected %h actual %h", name, expected, actual);
    endtask

    // each warp runs its own instructions in order on a private register file
    task automatic build_program();
        logic [31:0]        r;
        logic [PC_BITS-1:0] next_pc   [NUM_WARPS];
        logic [XLEN-1:0]    golden_rf [NUM_WARPS][NUM_REGS];
        int                 w;
        r = SEED;
        for (int i = 0; i < NUM_WARPS; i++) begin
            next_pc[i] = 32'h1000 * (i + 1);
            warp_cnt[i] = 0;
            for (int k = 0; k < NUM_REGS; k++) begin
                golden_rf[i][k] = '0;
            end
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            r = xorshift32(r);
            w = int'(r[1:0]);
            gen_wid[i] = r[1:0];
            gen_pc[i] = next_pc[w];
            next_pc[w] = next_pc[w] + 32'd4;
            gen_ex[i] = ex_type_t'(r[2]);
            gen_op[i] = op_type_t'(r[4:3]);
            gen_wb[i] = (r[7:5] != 3'd0);
            gen_rd[i] = REG_BITS'(r[9:8]);
            gen_rs1[i] = REG_BITS'(r[11:10]);
            gen_rs2[i] = REG_BITS'(r[13:12]);
            exp_rs1[i] = golden_rf[w][gen_rs1[i]];
            exp_rs2[i] = golden_rf[w][gen_rs2[i]];
            // register 0 is never written and keeps reading zero
            if (gen_wb[i] && gen_rd[i] != '0) begin
                golden_rf[w][gen_rd[i]] = exec_ref(gen_op[i], exp_rs1[i], exp_rs2[i], gen_pc[i]);
            end
            warp_list[w][warp_cnt[w]] = i;
            warp_cnt[w] = warp_cnt[w] + 1;
        end
    endtask

    // decode source and the two execution units
    always @(posedge clk) begin
        logic [XLEN-1:0] result;
        if (reset) begin
            stim_rng = SEED;
            stim_cycle = 0;
            sent = 0;
            decode_valid <= 1'b0;
            writeback_valid <= 1'b0;
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                dispatch_ready[u] <= 1'b0;
            end
        end else begin
            stim_cycle = stim_cycle + 1;
            if (decode_valid && decode_ready) begin
                sent = sent + 1;
            end
            // an offered instruction stays put until it is taken
            if (!decode_valid || decode_ready) begin
                stim_rng = xorshift32(stim_rng);
                if (sent < NUM_INSTR && stim_rng[2:0] != 3'd0) begin
                    decode_valid <= 1'b1;
                    decode_wid <= gen_wid[sent];
                    decode_pc <= gen_pc[sent];
                    decode_ex_type <= gen_ex[sent];
                    decode_op_type <= gen_op[sent];
                    decode_wb <= gen_wb[sent];
                    decode_rd <= gen_rd[sent];
                    decode_rs1 <= gen_rs1[sent];
                    decode_rs2 <= gen_rs2[sent];
                end else begin
                    decode_valid <= 1'b0;
                end
            end
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                if (dispatch_valid[u] && dispatch_ready[u] && dispatch_wb[u]) begin
                    stim_rng = xorshift32(stim_rng);
                    result = exec_ref(dispatch_op_type[u], dispatch_rs1_data[u],
                                      dispatch_rs2_data[u], dispatch_pc[u]);
                    wbq_wid.push_back(dispatch_wid[u]);
                    wbq_rd.push_back(dispatch_rd[u]);
                    wbq_data.push_back(result);
                    wbq_due.push_back(stim_cycle + int'(stim_rng[1:0]));
                end
                stim_rng = xorshift32(stim_rng);
                dispatch_ready[u] <= (stim_rng[1:0] != 2'd0);
            end
            // at most one writeback per cycle, oldest result first
            if (wbq_due.size() > 0 && wbq_due[0] <= stim_cycle) begin
                writeback_valid <= 1'b1;
                writeback_wid <= wbq_wid.pop_front();
                writeback_rd <= wbq_rd.pop_front();
                writeback_data <= wbq_data.pop_front();
                void'(wbq_due.pop_front());
            end else begin
                writeback_valid <= 1'b0;
            end
        end
    end

    // compares every dispatched instruction with the head of its warp's program
    always @(posedge clk) begin
        int w;
        int idx;
        // reset values are visible from the second reset edge through the first cycle after it
        if (reset_d) begin
            assert (!dispatch_valid[0] && !dispatch_valid[1] && !warp_issued) else
                report_mismatch("reset_outputs", 32'd0,
                                {29'd0, dispatch_valid[0], dispatch_valid[1], warp_issued});
        end
        reset_d <= reset;
        if (reset) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                warp_head[i] = 0;
            end
        end else begin
            if (warp_issued) begin
                issued = issued + 1;
            end
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                if (dispatch_valid[u] && dispatch_ready[u]) begin
                    dispatched = dispatched + 1;
                    w = int'(dispatch_wid[u]);
                    if (warp_head[w] >= warp_cnt[w]) begin
                        other_errors = other_errors + 1;
                        $display("warp %0d dispatched more instructions than it was given", w);
                    end else begin
                        idx = warp_list[w][warp_head[w]];
                        warp_head[w] = warp_head[w] + 1;
                        assert (dispatch_pc[u] == gen_pc[idx]) else
                            report_mismatch("pc_order", gen_pc[idx], dispatch_pc[u]);
                        assert (dispatch_rs1_data[u] == exp_rs1[idx]) else
                            report_mismatch("rs1_data", exp_rs1[idx], dispatch_rs1_data[u]);
                        assert (dispatch_rs2_data[u] == exp_rs2[idx]) else
                            report_mismatch("rs2_data", exp_rs2[idx], dispatch_rs2_data[u]);
                        assert (int'(gen_ex[idx]) == u) else
                            report_mismatch("ex_unit", 32'(gen_ex[idx]), u);
                        assert (dispatch_op_type[u] == gen_op[idx]) else
                            report_mismatch("op_type", 32'(gen_op[idx]),
                                            32'(dispatch_op_type[u]));
                        assert (dispatch_wb[u] == gen_wb[idx]) else
                            report_mismatch("wb", 32'(gen_wb[idx]), 32'(dispatch_wb[u]));
                        assert (dispatch_rd[u] == gen_rd[idx]) else
                            report_mismatch("rd", 32'(gen_rd[idx]), 32'(dispatch_rd[u]));
                    end
                end
            end
        end
    end

    initial begin
        int waited;
        int end_errors;
        end_errors = 0;
        build_program();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        waited = 0;
        // sampled on the falling edge, after the compare process has run
        while (dispatched < NUM_INSTR && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (dispatched < NUM_INSTR) begin
            end_errors = end_errors + 1;
            $display("timeout: only %0d of %0d instructions dispatched after %0d cycles",
                     dispatched, NUM_INSTR, waited);
        end
        // a short tail lets any extra dispatch or issue show up
        repeat (20) @(negedge clk);
        assert (issued == NUM_INSTR) else begin
            end_errors = end_errors + 1;
            $display("Fail issue_count expected %0d actual %0d", NUM_INSTR, issued);
        end
        $display("errors: %0d value mismatches, %0d order failures, %0d end of run failures",
                 value_errors, other_errors, end_errors);
        if (value_errors + other_errors + end_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/dispatcher.sv ====
// each unit holds one instruction; a full unit stalls only instructions of its own ex_type
module dispatcher import issue_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    input  logic                opd_valid,
    output logic                opd_ready,
    input  logic [NW_BITS-1:0]  opd_wid,
    input  logic [PC_BITS-1:0]  opd_pc,
    input  ex_type_t            opd_ex_type,
    input  op_type_t            opd_op_type,
    input  logic                opd_wb,
    input  logic [REG_BITS-1:0] opd_rd,
    input  logic [XLEN-1:0]     opd_rs1_data,
    input  logic [XLEN-1:0]     opd_rs2_data,

    output logic                dispatch_valid    [NUM_EX_UNITS],
    input  logic                dispatch_ready    [NUM_EX_UNITS],
    output logic [NW_BITS-1:0]  dispatch_wid      [NUM_EX_UNITS],
    output logic [PC_BITS-1:0]  dispatch_pc       [NUM_EX_UNITS],
    output op_type_t            dispatch_op_type  [NUM_EX_UNITS],
    output logic                dispatch_wb       [NUM_EX_UNITS],
    output logic [REG_BITS-1:0] dispatch_rd       [NUM_EX_UNITS],
    output logic [XLEN-1:0]     dispatch_rs1_data [NUM_EX_UNITS],
    output logic [XLEN-1:0]     dispatch_rs2_data [NUM_EX_UNITS]
);
    logic full [NUM_EX_UNITS];
    logic load [NUM_EX_UNITS];

    // the target unit can take a new entry when empty or draining this cycle
    assign opd_ready = !full[opd_ex_type] || dispatch_ready[opd_ex_type];

    for (genvar u = 0; u < NUM_EX_UNITS; u++) begin : g_unit
        assign load[u] = opd_valid && opd_ready && (opd_ex_type == ex_type_t'(u));
        assign dispatch_valid[u] = full[u];

        always_ff @(posedge clk) begin
            if (reset) begin
                full[u] <= 1'b0;
            end else if (load[u]) begin
                full[u] <= 1'b1;
            end else if (dispatch_ready[u]) begin
                full[u] <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (load[u]) begin
                dispatch_wid[u]      <= opd_wid;
                dispatch_pc[u]       <= opd_pc;
                dispatch_op_type[u]  <= opd_op_type;
                dispatch_wb[u]       <= opd_wb;
                dispatch_rd[u]       <= opd_rd;
                dispatch_rs1_data[u] <= opd_rs1_data;
                dispatch_rs2_data[u] <= opd_rs2_data;
            end
        end
    end

endmodule

// ==== verilog/ibuffer.sv ====
// one FIFO of IBUF_DEPTH entries per warp; pointers wrap by overflow, so the depth is a power of two
module ibuffer import issue_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    input  logic                decode_valid,
    output logic                decode_ready,
    input  logic [NW_BITS-1:0]  decode_wid,
    input  logic [PC_BITS-1:0]  decode_pc,
    input  ex_type_t            decode_ex_type,
    input  op_type_t            decode_op_type,
    input  logic                decode_wb,
    input  logic [REG_BITS-1:0] decode_rd,
    input  logic [REG_BITS-1:0] decode_rs1,
    input  logic [REG_BITS-1:0] decode_rs2,

    output logic                ibuf_valid   [NUM_WARPS],
    input  logic                ibuf_ready   [NUM_WARPS],
    output logic [PC_BITS-1:0]  ibuf_pc      [NUM_WARPS],
    output ex_type_t            ibuf_ex_type [NUM_WARPS],
    output op_type_t            ibuf_op_type [NUM_WARPS],
    output logic                ibuf_wb      [NUM_WARPS],
    output logic [REG_BITS-1:0] ibuf_rd      [NUM_WARPS],
    output logic [REG_BITS-1:0] ibuf_rs1     [NUM_WARPS],
    output logic [REG_BITS-1:0] ibuf_rs2     [NUM_WARPS]
);
    logic [IBUF_BITS:0]   count  [NUM_WARPS];
    logic [IBUF_BITS-1:0] rd_ptr [NUM_WARPS];
    logic [IBUF_BITS-1:0] wr_ptr [NUM_WARPS];

    // entry storage, indexed by warp then slot
    logic [PC_BITS-1:0]  mem_pc      [NUM_WARPS][IBUF_DEPTH];
    ex_type_t            mem_ex_type [NUM_WARPS][IBUF_DEPTH];
    op_type_t            mem_op_type [NUM_WARPS][IBUF_DEPTH];
    logic                mem_wb      [NUM_WARPS][IBUF_DEPTH];
    logic [REG_BITS-1:0] mem_rd      [NUM_WARPS][IBUF_DEPTH];
    logic [REG_BITS-1:0] mem_rs1     [NUM_WARPS][IBUF_DEPTH];
    logic [REG_BITS-1:0] mem_rs2     [NUM_WARPS][IBUF_DEPTH];

    // only the addressed warp's occupancy matters for accepting a decode
    assign decode_ready = (count[decode_wid] != (IBUF_BITS + 1)'(IBUF_DEPTH));

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        logic push;
        logic pop;

        assign push = decode_valid && decode_ready && (decode_wid == NW_BITS'(w));
        assign pop  = ibuf_valid[w] && ibuf_ready[w];

        always_ff @(posedge clk) begin
            if (reset) begin
                count[w]  <= '0;
                rd_ptr[w] <= '0;
                wr_ptr[w] <= '0;
            end else begin
                if (push) begin
                    wr_ptr[w] <= wr_ptr[w] + 1'b1;
                end
                if (pop) begin
                    rd_ptr[w] <= rd_ptr[w] + 1'b1;
                end
                if (push && !pop) begin
                    count[w] <= count[w] + 1'b1;
                end else if (pop && !push) begin
                    count[w] <= count[w] - 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                mem_pc[w][wr_ptr[w]]      <= decode_pc;
                mem_ex_type[w][wr_ptr[w]] <= decode_ex_type;
                mem_op_type[w][wr_ptr[w]] <= decode_op_type;
                mem_wb[w][wr_ptr[w]]      <= decode_wb;
                mem_rd[w][wr_ptr[w]]      <= decode_rd;
                mem_rs1[w][wr_ptr[w]]     <= decode_rs1;
                mem_rs2[w][wr_ptr[w]]     <= decode_rs2;
            end
        end

        // the oldest entry is presented as the warp head
        assign ibuf_valid[w]   = (count[w] != '0);
        assign ibuf_pc[w]      = mem_pc[w][rd_ptr[w]];
        assign ibuf_ex_type[w] = mem_ex_type[w][rd_ptr[w]];
        assign ibuf_op_type[w] = mem_op_type[w][rd_ptr[w]];
        assign ibuf_wb[w]      = mem_wb[w][rd_ptr[w]];
        assign ibuf_rd[w]      = mem_rd[w][rd_ptr[w]];
        assign ibuf_rs1[w]     = mem_rs1[w][rd_ptr[w]];
        assign ibuf_rs2[w]     = mem_rs2[w][rd_ptr[w]];
    end

endmodule

// ==== verilog/issue_pkg.sv ====
// sizes are fixed for one slice of 4 warps; IBUF_DEPTH must stay a power of two
package issue_pkg;

    // warps served by this slice
    localparam int NUM_WARPS = 4;
    localparam int NW_BITS = 2;

    // architectural registers per warp, register 0 reads as zero
    localparam int NUM_REGS = 32;
    localparam int REG_BITS = 5;

    localparam int XLEN = 32;
    localparam int PC_BITS = 32;

    // per-warp instruction buffer entries and the width of its pointers
    localparam int IBUF_DEPTH = 2;
    localparam int IBUF_BITS = 1;

    // one dispatch output per execution type
    localparam int NUM_EX_UNITS = 2;

    // execution type also serves as the dispatch output index
    typedef enum logic [0:0] {
        EX_ALU = 1'b0,
        EX_LSU = 1'b1
    } ex_type_t;

    // passed through the stage untouched
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } op_type_t;

endpackage

// ==== verilog/issue_slice.sv ====
// one decode source, one ack-free writeback port per cycle, dispatch outputs indexed by ex_type
module issue_slice import issue_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    input  logic                decode_valid,
    output logic                decode_ready,
    input  logic [NW_BITS-1:0]  decode_wid,
    input  logic [PC_BITS-1:0]  decode_pc,
    input  ex_type_t            decode_ex_type,
    input  op_type_t            decode_op_type,
    input  logic                decode_wb,
    input  logic [REG_BITS-1:0] decode_rd,
    input  logic [REG_BITS-1:0] decode_rs1,
    input  logic [REG_BITS-1:0] decode_rs2,

    input  logic                writeback_valid,
    input  logic [NW_BITS-1:0]  writeback_wid,
    input  logic [REG_BITS-1:0] writeback_rd,
    input  logic [XLEN-1:0]     writeback_data,

    output logic                dispatch_valid    [NUM_EX_UNITS],
    input  logic                dispatch_ready    [NUM_EX_UNITS],
    output logic [NW_BITS-1:0]  dispatch_wid      [NUM_EX_UNITS],
    output logic [PC_BITS-1:0]  dispatch_pc       [NUM_EX_UNITS],
    output op_type_t            dispatch_op_type  [NUM_EX_UNITS],
    output logic                dispatch_wb       [NUM_EX_UNITS],
    output logic [REG_BITS-1:0] dispatch_rd       [NUM_EX_UNITS],
    output logic [XLEN-1:0]     dispatch_rs1_data [NUM_EX_UNITS],
    output logic [XLEN-1:0]     dispatch_rs2_data [NUM_EX_UNITS],

    output logic                warp_issued
);
    // per-warp buffer heads
    logic                ibuf_valid   [NUM_WARPS];
    logic                ibuf_ready   [NUM_WARPS];
    logic [PC_BITS-1:0]  ibuf_pc      [NUM_WARPS];
    ex_type_t            ibuf_ex_type [NUM_WARPS];
    op_type_t            ibuf_op_type [NUM_WARPS];
    logic                ibuf_wb      [NUM_WARPS];
    logic [REG_BITS-1:0] ibuf_rd      [NUM_WARPS];
    logic [REG_BITS-1:0] ibuf_rs1     [NUM_WARPS];
    logic [REG_BITS-1:0] ibuf_rs2     [NUM_WARPS];

    // scoreboard to operand stage
    logic                sel_valid;
    logic                sel_ready;
    logic [NW_BITS-1:0]  sel_wid;
    logic [PC_BITS-1:0]  sel_pc;
    ex_type_t            sel_ex_type;
    op_type_t            sel_op_type;
    logic                sel_wb;
    logic [REG_BITS-1:0] sel_rd;
    logic [REG_BITS-1:0] sel_rs1;
    logic [REG_BITS-1:0] sel_rs2;

    // operand stage to dispatcher
    logic                opd_valid;
    logic                opd_ready;
    logic [NW_BITS-1:0]  opd_wid;
    logic [PC_BITS-1:0]  opd_pc;
    ex_type_t            opd_ex_type;
    op_type_t            opd_op_type;
    logic                opd_wb;
    logic [REG_BITS-1:0] opd_rd;
    logic [XLEN-1:0]     opd_rs1_data;
    logic [XLEN-1:0]     opd_rs2_data;

    ibuffer ibuffer (
        .clk            (clk),
        .reset          (reset),
        .decode_valid   (decode_valid),
        .decode_ready   (decode_ready),
        .decode_wid     (decode_wid),
        .decode_pc      (decode_pc),
        .decode_ex_type (decode_ex_type),
        .decode_op_type (decode_op_type),
        .decode_wb      (decode_wb),
        .decode_rd      (decode_rd),
        .decode_rs1     (decode_rs1),
        .decode_rs2     (decode_rs2),
        .ibuf_valid     (ibuf_valid),
        .ibuf_ready     (ibuf_ready),
        .ibuf_pc        (ibuf_pc),
        .ibuf_ex_type   (ibuf_ex_type),
        .ibuf_op_type   (ibuf_op_type),
        .ibuf_wb        (ibuf_wb),
        .ibuf_rd        (ibuf_rd),
        .ibuf_rs1       (ibuf_rs1),
        .ibuf_rs2       (ibuf_rs2)
    );

    scoreboard scoreboard (
        .clk             (clk),
        .reset           (reset),
        .ibuf_valid      (ibuf_valid),
        .ibuf_ready      (ibuf_ready),
        .ibuf_pc         (ibuf_pc),
        .ibuf_ex_type    (ibuf_ex_type),
        .ibuf_op_type    (ibuf_op_type),
        .ibuf_wb         (ibuf_wb),
        .ibuf_rd         (ibuf_rd),
        .ibuf_rs1        (ibuf_rs1),
        .ibuf_rs2        (ibuf_rs2),
        .writeback_valid (writeback_valid),
        .writeback_wid   (writeback_wid),
        .writeback_rd    (writeback_rd),
        .sel_valid       (sel_valid),
        .sel_ready       (sel_ready),
        .sel_wid         (sel_wid),
        .sel_pc          (sel_pc),
        .sel_ex_type     (sel_ex_type),
        .sel_op_type     (sel_op_type),
        .sel_wb          (sel_wb),
        .sel_rd          (sel_rd),
        .sel_rs1         (sel_rs1),
        .sel_rs2         (sel_rs2),
        .warp_issued     (warp_issued)
    );

    operands operands (
        .clk             (clk),
        .reset           (reset),
        .sel_valid       (sel_valid),
        .sel_ready       (sel_ready),
        .sel_wid         (sel_wid),
        .sel_pc          (sel_pc),
        .sel_ex_type     (sel_ex_type),
        .sel_op_type     (sel_op_type),
        .sel_wb          (sel_wb),
        .sel_rd          (sel_rd),
        .sel_rs1         (sel_rs1),
        .sel_rs2         (sel_rs2),
        .writeback_valid (writeback_valid),
        .writeback_wid   (writeback_wid),
        .writeback_rd    (writeback_rd),
        .writeback_data  (writeback_data),
        .opd_valid       (opd_valid),
        .opd_ready       (opd_ready),
        .opd_wid         (opd_wid),
        .opd_pc          (opd_pc),
        .opd_ex_type     (opd_ex_type),
        .opd_op_type     (opd_op_type),
        .opd_wb          (opd_wb),
        .opd_rd          (opd_rd),
        .opd_rs1_data    (opd_rs1_data),
        .opd_rs2_data    (opd_rs2_data)
    );

    dispatcher dispatcher (
        .clk               (clk),
        .reset             (reset),
        .opd_valid         (opd_valid),
        .opd_ready         (opd_ready),
        .opd_wid           (opd_wid),
        .opd_pc            (opd_pc),
        .opd_ex_type       (opd_ex_type),
        .opd_op_type       (opd_op_type),
        .opd_wb            (opd_wb),
        .opd_rd            (opd_rd),
        .opd_rs1_data      (opd_rs1_data),
        .opd_rs2_data      (opd_rs2_data),
        .dispatch_valid    (dispatch_valid),
        .dispatch_ready    (dispatch_ready),
        .dispatch_wid      (dispatch_wid),
        .dispatch_pc       (dispatch_pc),
        .dispatch_op_type  (dispatch_op_type),
        .dispatch_wb       (dispatch_wb),
        .dispatch_rd       (dispatch_rd),
        .dispatch_rs1_data (dispatch_rs1_data),
        .dispatch_rs2_data (dispatch_rs2_data)
    );

endmodule

// ==== verilog/operands.sv ====
// no write bypass; the scoreboard keeps any reader away until the cycle after its writeback
module operands import issue_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    input  logic                sel_valid,
    output logic                sel_ready,
    input  logic [NW_BITS-1:0]  sel_wid,
    input  logic [PC_BITS-1:0]  sel_pc,
    input  ex_type_t            sel_ex_type,
    input  op_type_t            sel_op_type,
    input  logic                sel_wb,
    input  logic [REG_BITS-1:0] sel_rd,
    input  logic [REG_BITS-1:0] sel_rs1,
    input  logic [REG_BITS-1:0] sel_rs2,

    input  logic                writeback_valid,
    input  logic [NW_BITS-1:0]  writeback_wid,
    input  logic [REG_BITS-1:0] writeback_rd,
    input  logic [XLEN-1:0]     writeback_data,

    output logic                opd_valid,
    input  logic                opd_ready,
    output logic [NW_BITS-1:0]  opd_wid,
    output logic [PC_BITS-1:0]  opd_pc,
    output ex_type_t            opd_ex_type,
    output op_type_t            opd_op_type,
    output logic                opd_wb,
    output logic [REG_BITS-1:0] opd_rd,
    output logic [XLEN-1:0]     opd_rs1_data,
    output logic [XLEN-1:0]     opd_rs2_data
);
    logic [XLEN-1:0] rf [NUM_WARPS][NUM_REGS];
    logic            sel_fire;

    // accept a new instruction while the held one leaves
    assign sel_ready = !opd_valid || opd_ready;
    assign sel_fire  = sel_valid && sel_ready;

    // register 0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk) begin
        if (reset) begin
            rf <= '{default: '0};
        end else if (writeback_valid && writeback_rd != '0) begin
            rf[writeback_wid][writeback_rd] <= writeback_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opd_valid <= 1'b0;
        end else if (sel_fire) begin
            opd_valid <= 1'b1;
        end else if (opd_ready) begin
            opd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_fire) begin
            opd_wid      <= sel_wid;
            opd_pc       <= sel_pc;
            opd_ex_type  <= sel_ex_type;
            opd_op_type  <= sel_op_type;
            opd_wb       <= sel_wb;
            opd_rd       <= sel_rd;
            opd_rs1_data <= rf[sel_wid][sel_rs1];
            opd_rs2_data <= rf[sel_wid][sel_rs2];
        end
    end

endmodule

// ==== verilog/scoreboard.sv ====
// rd is marked pending only when the selected instruction is taken; register 0 never goes pending
module scoreboard import issue_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    input  logic                ibuf_valid   [NUM_WARPS],
    output logic                ibuf_ready   [NUM_WARPS],
    input  logic [PC_BITS-1:0]  ibuf_pc      [NUM_WARPS],
    input  ex_type_t            ibuf_ex_type [NUM_WARPS],
    input  op_type_t            ibuf_op_type [NUM_WARPS],
    input  logic                ibuf_wb      [NUM_WARPS],
    input  logic [REG_BITS-1:0] ibuf_rd      [NUM_WARPS],
    input  logic [REG_BITS-1:0] ibuf_rs1     [NUM_WARPS],
    input  logic [REG_BITS-1:0] ibuf_rs2     [NUM_WARPS],

    input  logic                writeback_valid,
    input  logic [NW_BITS-1:0]  writeback_wid,
    input  logic [REG_BITS-1:0] writeback_rd,

    output logic                sel_valid,
    input  logic                sel_ready,
    output logic [NW_BITS-1:0]  sel_wid,
    output logic [PC_BITS-1:0]  sel_pc,
    output ex_type_t            sel_ex_type,
    output op_type_t            sel_op_type,
    output logic                sel_wb,
    output logic [REG_BITS-1:0] sel_rd,
    output logic [REG_BITS-1:0] sel_rs1,
    output logic [REG_BITS-1:0] sel_rs2,

    output logic                warp_issued
);
    logic [NUM_REGS-1:0] pending   [NUM_WARPS];
    logic [NUM_REGS-1:0] pending_n [NUM_WARPS];
    logic                hazard_n  [NUM_WARPS];
    logic                ready_r   [NUM_WARPS];
    logic [NW_BITS-1:0]  rr_ptr;
    logic [NW_BITS-1:0]  pick_wid;
    logic                pick_valid;
    logic                sel_fire;
    logic                load_en;

    assign sel_fire    = sel_valid && sel_ready;
    assign warp_issued = sel_fire;

    // pending state after this edge, with issue winning over a writeback to the same register
    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            pending_n[w] = pending[w];
            if (writeback_valid && writeback_wid == NW_BITS'(w)) begin
                pending_n[w][writeback_rd] = 1'b0;
            end
            if (sel_fire && sel_wb && sel_rd != '0 && sel_wid == NW_BITS'(w)) begin
                pending_n[w][sel_rd] = 1'b1;
            end
        end
    end

    // an instruction waiting in the output register still blocks younger readers of its rd
    always_comb begin
        logic [NUM_REGS-1:0] busy;
        for (int w = 0; w < NUM_WARPS; w++) begin
            busy = pending_n[w];
            if (sel_valid && !sel_fire && sel_wb && sel_rd != '0 && sel_wid == NW_BITS'(w)) begin
                busy[sel_rd] = 1'b1;
            end
            hazard_n[w] = busy[ibuf_rs1[w]] || busy[ibuf_rs2[w]]
                       || (ibuf_wb[w] && busy[ibuf_rd[w]]);
        end
    end

    // eligibility is registered, so a new head waits one cycle before it can be picked
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '{default: '0};
            ready_r <= '{default: 1'b0};
        end else begin
            pending <= pending_n;
            for (int w = 0; w < NUM_WARPS; w++) begin
                ready_r[w] <= ibuf_valid[w] && !ibuf_ready[w] && !hazard_n[w];
            end
        end
    end

    // round-robin search begins just after the last warp chosen
    always_comb begin
        logic [NW_BITS-1:0] idx;
        pick_valid = 1'b0;
        pick_wid   = '0;
        for (int i = 1; i <= NUM_WARPS; i++) begin
            idx = rr_ptr + NW_BITS'(i);
            if (!pick_valid && ready_r[idx]) begin
                pick_valid = 1'b1;
                pick_wid   = idx;
            end
        end
    end

    assign load_en = pick_valid && (!sel_valid || sel_ready);

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            ibuf_ready[w] = load_en && (pick_wid == NW_BITS'(w));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_valid <= 1'b0;
            rr_ptr    <= NW_BITS'(NUM_WARPS - 1);
        end else begin
            if (load_en) begin
                sel_valid <= 1'b1;
                rr_ptr    <= pick_wid;
            end else if (sel_ready) begin
                sel_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            sel_wid     <= pick_wid;
            sel_pc      <= ibuf_pc[pick_wid];
            sel_ex_type <= ibuf_ex_type[pick_wid];
            sel_op_type <= ibuf_op_type[pick_wid];
            sel_wb      <= ibuf_wb[pick_wid];
            sel_rd      <= ibuf_rd[pick_wid];
            sel_rs1     <= ibuf_rs1[pick_wid];
            sel_rs2     <= ibuf_rs2[pick_wid];
        end
    end

endmodule
